// ==== hdl/mci_cfg.svh ====
// Memory map and sizes for the MCI subordinate. Window sizes must be powers of two and word aligned
`ifndef MCI_CFG_SVH
`define MCI_CFG_SVH

// Bus widths
`define MCI_ADDR_W      32
`define MCI_DATA_W      32
`define MCI_USER_W      8

// Mailbox count and valid-user entries per mailbox
`define MCI_NUM_MBOX    2
`define MCI_MBOX_USERS  5

// Register window with the read-only ID at word 15
`define MCI_REG_BASE    32'h0000_0000
`define MCI_REG_BYTES   64
`define MCI_REG_ID_WORD 15
`define MCI_REG_ID      32'h4D43_4931

// Mailbox i lives at base + i * stride
`define MCI_MBOX_BASE   32'h0008_0000
`define MCI_MBOX_STRIDE 32'h0001_0000
`define MCI_MBOX_BYTES  256

// Local SRAM
`define MCI_SRAM_BASE   32'h0020_0000
`define MCI_SRAM_KB     1
`define MCI_SRAM_BYTES  (`MCI_SRAM_KB * 1024)

// Always-valid mailbox user
`define MCI_DEF_USER    8'hFF

// Targets are regs, SRAM, then the mailboxes
`define MCI_NUM_TGT     (2 + `MCI_NUM_MBOX)

`endif

// ==== hdl/mci_mbox.sv ====
// Mailbox without doorbells. Expects full-word requests, as the decoder only passes those
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_mbox (
    input  logic              clk,
    input  logic              rst,
    input  logic              dv,
    input  mci_pkg::mci_req_t req,
    output mci_pkg::mci_rsp_t rsp
);

    localparam int mbox_aw = $clog2(`MCI_MBOX_BYTES);
    localparam int depth   = `MCI_MBOX_BYTES / 4;

    mci_pkg::data_t     mem [depth];
    logic [mbox_aw-3:0] word;
    logic               lock_word;
    logic               lock_q;
    logic               rd_start;
    logic               rd_pend;
    mci_pkg::data_t     rd_data;

    assign word      = req.addr[mbox_aw-1:2];
    // Word 0 is the lock
    assign lock_word = word == '0;
    assign rd_start  = dv & ~req.write & ~rd_pend;

    //////////////////////////////////////////////////////////////////////////////
    // Lock
    //////////////////////////////////////////////////////////////////////////////

    // Read acquires, any write releases
    always_ff @(posedge clk) begin
        if (rst) begin
            lock_q <= 1'b0;
        end else if (dv & req.write & lock_word) begin
            lock_q <= 1'b0;
        end else if (rd_start & lock_word) begin
            lock_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Data words
    //////////////////////////////////////////////////////////////////////////////

    // Writes land only while locked
    always_ff @(posedge clk) begin
        if (dv & req.write & ~lock_word & lock_q) begin
            mem[word] <= req.wdata;
        end
        // Lock read returns the value before the acquire
        if (rd_start) begin
            rd_data <= lock_word ? mci_pkg::data_t'(lock_q) : mem[word];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_start;
        end
    end

    always_comb begin
        rsp.rdata = rd_pend ? rd_data : '0;
        rsp.hold  = rd_start;
        rsp.error = dv & req.write & ~lock_word & ~lock_q;
    end

endmodule

// ==== hdl/mci_pkg.sv ====
// Shared MCI types. Field widths follow mci_cfg.svh and change with it
`include "mci_cfg.svh"

package mci_pkg;

    // Bus field vectors
    typedef logic [`MCI_ADDR_W-1:0]   addr_t;
    typedef logic [`MCI_DATA_W-1:0]   data_t;
    typedef logic [`MCI_DATA_W/8-1:0] strb_t;
    typedef logic [`MCI_USER_W-1:0]   user_t;

    // One request as the SoC presents it
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
        logic  write;
        user_t user;
    } mci_req_t;

    // Response back to the requester
    // Hold high means keep the request stable
    typedef struct packed {
        data_t rdata;
        logic  hold;
        logic  error;
    } mci_rsp_t;

    // Valid-user list of one mailbox
    typedef user_t [`MCI_MBOX_USERS-1:0] mci_user_list_t;

    // One-hot target select
    typedef logic [`MCI_NUM_TGT-1:0] tgt_sel_t;

    // Bit positions inside tgt_sel_t
    // Mailbox i sits at tgt_mbox0 + i
    typedef enum int unsigned {
        tgt_reg   = 0,
        tgt_sram  = 1,
        tgt_mbox0 = 2
    } tgt_e;

endpackage

// ==== hdl/mci_regs.sv ====
// Full-word accesses only. Words beyond the user lists read zero, and writes to them or the ID fail
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_regs (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        dv,
    input  mci_pkg::mci_req_t                           req,
    output mci_pkg::mci_rsp_t                           rsp,
    output mci_pkg::mci_user_list_t [`MCI_NUM_MBOX-1:0] mbox_users
);

    localparam int reg_aw    = $clog2(`MCI_REG_BYTES);
    localparam int num_users = `MCI_NUM_MBOX * `MCI_MBOX_USERS;

    mci_pkg::mci_user_list_t [`MCI_NUM_MBOX-1:0] users_q;
    logic [reg_aw-3:0] word;
    logic              user_word;
    logic              rd_start;
    logic              rd_pend;
    mci_pkg::data_t    rd_word;
    mci_pkg::data_t    rd_data;

    // Entry e of mailbox m at word m * users + e
    assign word      = req.addr[reg_aw-1:2];
    assign user_word = word < num_users;
    // First cycle of a read
    assign rd_start  = dv & ~req.write & ~rd_pend;

    // Read mux
    always_comb begin
        rd_word = '0;
        if (word == `MCI_REG_ID_WORD) begin
            rd_word = `MCI_REG_ID;
        end
        for (int m = 0; m < `MCI_NUM_MBOX; m++) begin
            for (int e = 0; e < `MCI_MBOX_USERS; e++) begin
                if (word == m * `MCI_MBOX_USERS + e) begin
                    rd_word = mci_pkg::data_t'(users_q[m][e]);
                end
            end
        end
    end

    // User lists, user in the low byte
    always_ff @(posedge clk) begin
        if (rst) begin
            users_q <= '0;
        end else if (dv & req.write) begin
            for (int m = 0; m < `MCI_NUM_MBOX; m++) begin
                for (int e = 0; e < `MCI_MBOX_USERS; e++) begin
                    if (word == m * `MCI_MBOX_USERS + e) begin
                        users_q[m][e] <= req.wdata[`MCI_USER_W-1:0];
                    end
                end
            end
        end
    end

    // Read takes one hold cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_start;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_data <= rd_word;
        end
    end

    always_comb begin
        rsp.rdata = rd_pend ? rd_data : '0;
        rsp.hold  = rd_start;
        rsp.error = dv & req.write & ~user_word;
    end

    assign mbox_users = users_q;

endmodule

// ==== hdl/mci_resp_merge.sv ====
// Assumes a one-hot or empty select. Two live targets would OR their responses together
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_resp_merge (
    input  mci_pkg::tgt_sel_t                     tgt_sel,
    input  logic                                  req_miss,
    input  mci_pkg::mci_rsp_t                     reg_rsp,
    input  mci_pkg::mci_rsp_t                     sram_rsp,
    input  mci_pkg::mci_rsp_t [`MCI_NUM_MBOX-1:0] mbox_rsp,
    output mci_pkg::mci_rsp_t                     soc_rsp
);

    localparam int rsp_w = $bits(mci_pkg::mci_rsp_t);

    // AND-OR merge, each response masked by its select bit
    always_comb begin
        soc_rsp = reg_rsp & {rsp_w{tgt_sel[mci_pkg::tgt_reg]}};
        soc_rsp = soc_rsp | (sram_rsp & {rsp_w{tgt_sel[mci_pkg::tgt_sram]}});
        for (int i = 0; i < `MCI_NUM_MBOX; i++) begin
            soc_rsp = soc_rsp | (mbox_rsp[i] & {rsp_w{tgt_sel[mci_pkg::tgt_mbox0 + i]}});
        end
        // Miss leaves rdata and hold at zero
        soc_rsp.error = soc_rsp.error | req_miss;
    end

endmodule

// ==== hdl/mci_sram.sv ====
// Byte-writable SRAM without ECC. Contents are undefined until written
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_sram (
    input  logic              clk,
    input  logic              rst,
    input  logic              dv,
    input  mci_pkg::mci_req_t req,
    output mci_pkg::mci_rsp_t rsp
);

    localparam int sram_aw   = $clog2(`MCI_SRAM_BYTES);
    localparam int depth     = `MCI_SRAM_BYTES / 4;
    localparam int num_bytes = $bits(mci_pkg::strb_t);

    mci_pkg::data_t    mem [depth];
    logic [sram_aw-3:0] idx;
    logic              rd_start;
    logic              rd_pend;
    mci_pkg::data_t    rd_data;

    // Word index from the window offset
    assign idx      = req.addr[sram_aw-1:2];
    assign rd_start = dv & ~req.write & ~rd_pend;

    // Strobed bytes only
    always_ff @(posedge clk) begin
        if (dv & req.write) begin
            for (int b = 0; b < num_bytes; b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
        if (rd_start) begin
            rd_data <= mem[idx];
        end
    end

    // Second read cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_start;
        end
    end

    // Never errors
    always_comb begin
        rsp.rdata = rd_pend ? rd_data : '0;
        rsp.hold  = rd_start;
        rsp.error = 1'b0;
    end

endmodule

// ==== hdl/mci_sub_decode.sv ====
// Fully combinational decode. Accepts only one request at a time and never holds by itself
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_sub_decode (
    input  logic                                        soc_dv,
    input  mci_pkg::mci_req_t                           soc_req,
    input  mci_pkg::mci_user_list_t [`MCI_NUM_MBOX-1:0] mbox_users,
    input  mci_pkg::user_t                              strap_mcu_lsu_user,
    input  mci_pkg::user_t                              strap_mcu_ifu_user,
    input  mci_pkg::user_t                              strap_debug_user,
    output logic                                        reg_dv,
    output logic                                        sram_dv,
    output logic [`MCI_NUM_MBOX-1:0]                    mbox_dv,
    output mci_pkg::tgt_sel_t                           tgt_sel,
    output logic                                        req_miss,
    output logic                                        axi_mcu_req,
    output logic                                        axi_debug_req
);

    // Window bounds
    localparam mci_pkg::addr_t reg_lo  = `MCI_REG_BASE;
    localparam mci_pkg::addr_t reg_hi  = `MCI_REG_BASE + `MCI_REG_BYTES - 1;
    localparam mci_pkg::addr_t sram_lo = `MCI_SRAM_BASE;
    localparam mci_pkg::addr_t sram_hi = `MCI_SRAM_BASE + `MCI_SRAM_BYTES - 1;

    logic                     all_strb;
    logic                     reg_hit;
    logic                     sram_hit;
    logic [`MCI_NUM_MBOX-1:0] mbox_hit;
    logic [`MCI_NUM_MBOX-1:0] mbox_user_ok;
    logic                     debug_disable;
    logic                     debug_force;
    logic                     debug_match;

    //////////////////////////////////////////////////////////////////////////////
    // Privileged users
    //////////////////////////////////////////////////////////////////////////////

    // All zeros turns debug detection off
    assign debug_disable = ~|strap_debug_user;
    // All ones makes every request a debug request
    assign debug_force   = &strap_debug_user;
    assign debug_match   = soc_req.user == strap_debug_user;

    assign axi_debug_req = soc_dv & ((debug_match & ~debug_disable) | debug_force);

    // LSU or IFU strap
    assign axi_mcu_req = soc_dv & ((soc_req.user == strap_mcu_lsu_user) |
                                   (soc_req.user == strap_mcu_ifu_user));

    //////////////////////////////////////////////////////////////////////////////
    // Address windows and qualifiers
    //////////////////////////////////////////////////////////////////////////////

    // Regs and mailboxes take full words only
    assign all_strb = &soc_req.wstrb;

    assign reg_hit  = soc_req.addr inside {[reg_lo:reg_hi]};
    assign sram_hit = soc_req.addr inside {[sram_lo:sram_hi]};

    for (genvar i = 0; i < `MCI_NUM_MBOX; i++) begin : g_mbox
        localparam mci_pkg::addr_t mbox_lo = `MCI_MBOX_BASE + i * `MCI_MBOX_STRIDE;
        localparam mci_pkg::addr_t mbox_hi = mbox_lo + `MCI_MBOX_BYTES - 1;

        assign mbox_hit[i] = soc_req.addr inside {[mbox_lo:mbox_hi]};

        // Listed user, default user or a privileged requester
        always_comb begin
            mbox_user_ok[i] = soc_req.user == `MCI_DEF_USER;
            for (int j = 0; j < `MCI_MBOX_USERS; j++) begin
                mbox_user_ok[i] |= soc_req.user == mbox_users[i][j];
            end
            mbox_user_ok[i] |= axi_mcu_req | axi_debug_req;
        end

        assign mbox_dv[i] = soc_dv & mbox_hit[i] & mbox_user_ok[i] & all_strb;
    end

    // SRAM takes any user and any strobes
    assign sram_dv = soc_dv & sram_hit;
    assign reg_dv  = soc_dv & reg_hit & all_strb;

    //////////////////////////////////////////////////////////////////////////////
    // Select toward the response merger
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        tgt_sel                    = '0;
        tgt_sel[mci_pkg::tgt_reg]  = reg_dv;
        tgt_sel[mci_pkg::tgt_sram] = sram_dv;
        for (int i = 0; i < `MCI_NUM_MBOX; i++) begin
            tgt_sel[mci_pkg::tgt_mbox0 + i] = mbox_dv[i];
        end
    end

    // Unmapped or disqualified
    assign req_miss = soc_dv & ~|tgt_sel;

endmodule

// ==== hdl/mci_top.sv ====
// MCI subordinate top. One request in flight, reads take two cycles and writes one
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              soc_dv,
    input  mci_pkg::mci_req_t soc_req,
    input  mci_pkg::user_t    strap_mcu_lsu_user,
    input  mci_pkg::user_t    strap_mcu_ifu_user,
    input  mci_pkg::user_t    strap_debug_user,
    output mci_pkg::mci_rsp_t soc_rsp,
    output logic              axi_mcu_req,
    output logic              axi_debug_req
);

    logic                                        reg_dv;
    logic                                        sram_dv;
    logic [`MCI_NUM_MBOX-1:0]                    mbox_dv;
    mci_pkg::tgt_sel_t                           tgt_sel;
    logic                                        req_miss;
    mci_pkg::mci_rsp_t                           reg_rsp;
    mci_pkg::mci_rsp_t                           sram_rsp;
    mci_pkg::mci_rsp_t [`MCI_NUM_MBOX-1:0]       mbox_rsp;
    mci_pkg::mci_user_list_t [`MCI_NUM_MBOX-1:0] mbox_users;

    // Decode and privilege detection
    mci_sub_decode u_decode (
        .soc_dv             (soc_dv),
        .soc_req            (soc_req),
        .mbox_users         (mbox_users),
        .strap_mcu_lsu_user (strap_mcu_lsu_user),
        .strap_mcu_ifu_user (strap_mcu_ifu_user),
        .strap_debug_user   (strap_debug_user),
        .reg_dv             (reg_dv),
        .sram_dv            (sram_dv),
        .mbox_dv            (mbox_dv),
        .tgt_sel            (tgt_sel),
        .req_miss           (req_miss),
        .axi_mcu_req        (axi_mcu_req),
        .axi_debug_req      (axi_debug_req)
    );

    // Targets all see the same request
    mci_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .dv         (reg_dv),
        .req        (soc_req),
        .rsp        (reg_rsp),
        .mbox_users (mbox_users)
    );

    mci_sram u_sram (
        .clk (clk),
        .rst (rst),
        .dv  (sram_dv),
        .req (soc_req),
        .rsp (sram_rsp)
    );

    for (genvar i = 0; i < `MCI_NUM_MBOX; i++) begin : g_mbox
        mci_mbox u_mbox (
            .clk (clk),
            .rst (rst),
            .dv  (mbox_dv[i]),
            .req (soc_req),
            .rsp (mbox_rsp[i])
        );
    end

    // Single response to the SoC
    mci_resp_merge u_merge (
        .tgt_sel  (tgt_sel),
        .req_miss (req_miss),
        .reg_rsp  (reg_rsp),
        .sram_rsp (sram_rsp),
        .mbox_rsp (mbox_rsp),
        .soc_rsp  (soc_rsp)
    );

endmodule

// ==== mci_top.f ====
+incdir+hdl
hdl/mci_pkg.sv
hdl/mci_sub_decode.sv
hdl/mci_regs.sv
hdl/mci_sram.sv
hdl/mci_mbox.sv
hdl/mci_resp_merge.sv
hdl/mci_top.sv
tb/mci_top_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f mci_top.f --top-module mci_top_tb -o mci_sim
./obj_dir/mci_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

// ==== tb/mci_top_tb.sv ====
// Table-driven MCI testbench. Assumes the default memory map and straps of 0x10, 0x11 and 0x20
`timescale 1ns/100ps
`include "mci_cfg.svh"

module mci_top_tb;

    // One stimulus row with its expected response
    typedef struct packed {
        logic           write;
        mci_pkg::addr_t addr;
        mci_pkg::data_t wdata;
        mci_pkg::strb_t wstrb;
        mci_pkg::user_t user;
        mci_pkg::user_t lsu;
        mci_pkg::user_t ifu;
        mci_pkg::user_t dbg;
        mci_pkg::data_t exp_rdata;
        logic           exp_err;
        logic           exp_mcu;
        logic           exp_dbg;
    } row_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              soc_dv;
    mci_pkg::mci_req_t soc_req;
    mci_pkg::user_t    strap_mcu_lsu_user;
    mci_pkg::user_t    strap_mcu_ifu_user;
    mci_pkg::user_t    strap_debug_user;
    mci_pkg::mci_rsp_t soc_rsp;
    logic              axi_mcu_req;
    logic              axi_debug_req;

    row_t           rows[$];
    string          names[$];
    mci_pkg::user_t cur_lsu;
    mci_pkg::user_t cur_ifu;
    mci_pkg::user_t cur_dbg;
    logic [31:0]    lcg_state = 32'd2370;
    int             errors = 0;

    // 4 ns clock
    always #2 clk = ~clk;

    mci_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .soc_dv             (soc_dv),
        .soc_req            (soc_req),
        .strap_mcu_lsu_user (strap_mcu_lsu_user),
        .strap_mcu_ifu_user (strap_mcu_ifu_user),
        .strap_debug_user   (strap_debug_user),
        .soc_rsp            (soc_rsp),
        .axi_mcu_req        (axi_mcu_req),
        .axi_debug_req      (axi_debug_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Strap rules, MCU flag in bit 1 and debug flag in bit 0
    function automatic logic [1:0] priv_flags(input mci_pkg::user_t user,
                                              input mci_pkg::user_t lsu,
                                              input mci_pkg::user_t ifu,
                                              input mci_pkg::user_t dbg);
        logic mcu;
        logic debug;
        mcu   = (user == lsu) || (user == ifu);
        // All ones forces, all zeros disables
        debug = (dbg == '1) || ((dbg != '0) && (user == dbg));
        return {mcu, debug};
    endfunction

    // Strobed bytes from the new word, the rest kept
    function automatic mci_pkg::data_t merge_bytes(input mci_pkg::data_t old_word,
                                                   input mci_pkg::data_t new_word,
                                                   input mci_pkg::strb_t strb);
        mci_pkg::data_t w;
        for (int b = 0; b < $bits(mci_pkg::strb_t); b++) begin
            w[b*8 +: 8] = strb[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return w;
    endfunction

    task automatic use_straps(input mci_pkg::user_t lsu, input mci_pkg::user_t ifu,
                              input mci_pkg::user_t dbg);
        cur_lsu = lsu;
        cur_ifu = ifu;
        cur_dbg = dbg;
    endtask

    task automatic add_row(input string name, input logic write, input mci_pkg::addr_t addr,
                           input mci_pkg::data_t wdata, input mci_pkg::strb_t wstrb,
                           input mci_pkg::user_t user, input mci_pkg::data_t exp_rdata,
                           input logic exp_err);
        row_t       r;
        logic [1:0] flags;
        flags       = priv_flags(user, cur_lsu, cur_ifu, cur_dbg);
        r.write     = write;
        r.addr      = addr;
        r.wdata     = wdata;
        r.wstrb     = wstrb;
        r.user      = user;
        r.lsu       = cur_lsu;
        r.ifu       = cur_ifu;
        r.dbg       = cur_dbg;
        r.exp_rdata = exp_rdata;
        r.exp_err   = exp_err;
        r.exp_mcu   = flags[1];
        r.exp_dbg   = flags[0];
        rows.push_back(r);
        names.push_back(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        mci_pkg::addr_t addr;
        mci_pkg::data_t base;
        mci_pkg::data_t patch;
        mci_pkg::strb_t strb;
        mci_pkg::user_t user;
        use_straps(8'h10, 8'h11, 8'h20);
        // SRAM, full fill then a partial patch, read back
        for (int k = 0; k < 8; k++) begin
            addr  = `MCI_SRAM_BASE + (lcg_next() & 32'h0000_03FC);
            base  = lcg_next();
            patch = lcg_next();
            // Never all four strobes
            strb  = mci_pkg::strb_t'(lcg_next() % 14 + 1);
            user  = mci_pkg::user_t'(lcg_next() >> 8);
            add_row($sformatf("sram_fill_%0d", k), 1, addr, base, 4'hF, user, 0, 0);
            add_row($sformatf("sram_patch_%0d", k), 1, addr, patch, strb, user, 0, 0);
            add_row($sformatf("sram_rd_%0d", k), 0, addr, 0, 4'hF, user,
                    merge_bytes(base, patch, strb), 0);
        end
        // Mailbox 0 entry 0 and mailbox 1 entry 0
        add_row("reg_wr_m0e0", 1, 32'h0000_0000, 32'h0000_0042, 4'hF, 8'h01, 0, 0);
        add_row("reg_rd_m0e0", 0, 32'h0000_0000, 0, 4'hF, 8'h01, 32'h0000_0042, 0);
        add_row("reg_wr_m1e0", 1, 32'h0000_0014, 32'h0000_0055, 4'hF, 8'h01, 0, 0);
        add_row("reg_rd_m1e0", 0, 32'h0000_0014, 0, 4'hF, 8'h01, 32'h0000_0055, 0);
        // Rest of the mailbox 0 list, so user zero is no longer listed there
        for (int e = 1; e < `MCI_MBOX_USERS; e++) begin
            add_row($sformatf("reg_wr_m0e%0d", e), 1, mci_pkg::addr_t'(e * 4),
                    mci_pkg::data_t'(8'h60 + e), 4'hF, 8'h01, 0, 0);
        end
        add_row("reg_wr_partial", 1, 32'h0000_0000, 32'h0000_0099, 4'h3, 8'h01, 0, 1);
        add_row("reg_rd_kept", 0, 32'h0000_0000, 0, 4'hF, 8'h01, 32'h0000_0042, 0);
        add_row("reg_wr_id", 1, 32'h0000_003C, 32'h0000_0000, 4'hF, 8'h01, 0, 1);
        add_row("reg_rd_id", 0, 32'h0000_003C, 0, 4'hF, 8'h01, `MCI_REG_ID, 0);
        // Lock acquire on mailbox 0
        add_row("lock_rd_first", 0, 32'h0008_0000, 0, 4'hF, 8'h42, 0, 0);
        add_row("lock_rd_second", 0, 32'h0008_0000, 0, 4'hF, 8'h42, 1, 0);
        // User qualifiers while locked
        add_row("mbox_wr_listed", 1, 32'h0008_0004, 32'h0000_00A1, 4'hF, 8'h42, 0, 0);
        add_row("mbox_rd_listed", 0, 32'h0008_0004, 0, 4'hF, 8'h42, 32'h0000_00A1, 0);
        add_row("mbox_wr_default", 1, 32'h0008_0008, 32'h0000_00A2, 4'hF, `MCI_DEF_USER, 0, 0);
        add_row("mbox_wr_lsu", 1, 32'h0008_000C, 32'h0000_00A3, 4'hF, 8'h10, 0, 0);
        add_row("mbox_wr_ifu", 1, 32'h0008_0010, 32'h0000_00A4, 4'hF, 8'h11, 0, 0);
        add_row("mbox_wr_debug", 1, 32'h0008_0014, 32'h0000_00A5, 4'hF, 8'h20, 0, 0);
        add_row("mbox_wr_unlisted", 1, 32'h0008_0014, 32'h0000_0BAD, 4'hF, 8'h33, 0, 1);
        add_row("mbox_wr_partial", 1, 32'h0008_0014, 32'h0000_0BAD, 4'h7, 8'h42, 0, 1);
        add_row("mbox_rd_unlisted", 0, 32'h0008_0014, 0, 4'hF, 8'h33, 0, 1);
        add_row("mbox_rd_kept", 0, 32'h0008_0014, 0, 4'hF, 8'h42, 32'h0000_00A5, 0);
        // Zero strap, user zero matches it but is no debug user
        use_straps(8'h10, 8'h11, 8'h00);
        add_row("mbox_wr_dbg_off", 1, 32'h0008_0014, 32'h0000_0BAD, 4'hF, 8'h00, 0, 1);
        use_straps(8'h10, 8'h11, 8'hFF);
        add_row("mbox_wr_dbg_all", 1, 32'h0008_0014, 32'h0000_00C3, 4'hF, 8'h33, 0, 0);
        use_straps(8'h10, 8'h11, 8'h20);
        add_row("mbox_rd_dbg_all", 0, 32'h0008_0014, 0, 4'hF, 8'h42, 32'h0000_00C3, 0);
        // Release, then data writes fail until the next acquire
        add_row("lock_release", 1, 32'h0008_0000, 32'h0000_0000, 4'hF, 8'h42, 0, 0);
        add_row("mbox_wr_unlocked", 1, 32'h0008_0004, 32'h0000_0BAD, 4'hF, 8'h42, 0, 1);
        add_row("mbox_rd_unlocked", 0, 32'h0008_0004, 0, 4'hF, 8'h42, 32'h0000_00A1, 0);
        add_row("lock_rd_again", 0, 32'h0008_0000, 0, 4'hF, 8'h42, 0, 0);
        // Mailbox 1 has its own list and lock
        add_row("mbox1_lock_rd", 0, 32'h0009_0000, 0, 4'hF, 8'h55, 0, 0);
        add_row("mbox1_wr_listed", 1, 32'h0009_0004, 32'h0000_00D1, 4'hF, 8'h55, 0, 0);
        add_row("mbox1_wr_other", 1, 32'h0009_0004, 32'h0000_0BAD, 4'hF, 8'h42, 0, 1);
        add_row("mbox1_rd_listed", 0, 32'h0009_0004, 0, 4'hF, 8'h55, 32'h0000_00D1, 0);
        // Holes in the map
        add_row("unmapped_rd_hi", 0, 32'h0010_0000, 0, 4'hF, 8'h42, 0, 1);
        add_row("unmapped_wr_gap", 1, 32'h0007_FFFC, 32'h1234_5678, 4'hF, 8'h42, 0, 1);
        add_row("unmapped_rd_reg", 0, 32'h0000_0040, 0, 4'hF, 8'h42, 0, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Row driver and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_row(input int i);
        row_t r;
        int   holds;
        int   exp_holds;
        r         = rows[i];
        holds     = 0;
        // Reads stall once, writes and errors never
        exp_holds = (!r.write && !r.exp_err) ? 1 : 0;
        @(negedge clk);
        soc_dv             = 1'b1;
        soc_req.addr       = r.addr;
        soc_req.wdata      = r.wdata;
        soc_req.wstrb      = r.wstrb;
        soc_req.write      = r.write;
        soc_req.user       = r.user;
        strap_mcu_lsu_user = r.lsu;
        strap_mcu_ifu_user = r.ifu;
        strap_debug_user   = r.dbg;
        // Response sampled 1 ns after the falling edge
        #1;
        while (soc_rsp.hold) begin
            holds++;
            @(negedge clk);
            #1;
        end
        // Completion cycle
        if (soc_rsp.rdata !== r.exp_rdata) begin
            $display("CHECK FAILED %s rdata expected %h actual %h",
                     names[i], r.exp_rdata, soc_rsp.rdata);
            errors++;
        end
        if (soc_rsp.error !== r.exp_err) begin
            $display("CHECK FAILED %s error expected %b actual %b",
                     names[i], r.exp_err, soc_rsp.error);
            errors++;
        end
        if (holds != exp_holds) begin
            $display("CHECK FAILED %s hold cycles expected %0d actual %0d",
                     names[i], exp_holds, holds);
            errors++;
        end
        if (axi_mcu_req !== r.exp_mcu) begin
            $display("CHECK FAILED %s axi_mcu_req expected %b actual %b",
                     names[i], r.exp_mcu, axi_mcu_req);
            errors++;
        end
        if (axi_debug_req !== r.exp_dbg) begin
            $display("CHECK FAILED %s axi_debug_req expected %b actual %b",
                     names[i], r.exp_dbg, axi_debug_req);
            errors++;
        end
    endtask

    initial begin
        rst                = 1'b1;
        soc_dv             = 1'b0;
        soc_req            = '0;
        strap_mcu_lsu_user = 8'h10;
        strap_mcu_ifu_user = 8'h11;
        strap_debug_user   = 8'h20;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        @(negedge clk);
        soc_dv = 1'b0;
        $display("Finished %0d rows with %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Ten cycles per row plus reset
    initial begin
        #1;
        repeat (rows.size() * 10 + 10) @(posedge clk);
        $display("Watchdog timeout, a transfer never completed");
        $display("=== FAIL ===");
        $finish;
    end

endmodule
